//--- Bender.yml
package:
  name: cpu

sources:
  - files:
      - logic/cpuPkg.sv
      - logic/wordMemory.sv
      - logic/registerFile.sv
      - logic/controlUnit.sv
      - logic/executeUnit.sv
      - logic/programCounter.sv
      - logic/cpu.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/cpuTb.sv

//--- logic/controlUnit.sv
`default_nettype none

module controlUnit (
  input  var   cpuPkg::opcode_t opcode,
  input  wire                   run,       // Low while the loader owns the core
  output logic                  regWrite,
  output logic                  memWrite,
  output logic                  memRead,
  output logic                  aluSrcImm, // Second operand from the immediate
  output logic                  srcFromRd, // First read port on rd for LLB/LHB
  output logic                  memToReg,
  output logic                  pcToReg,   // PCS write-back
  output logic                  branch,
  output logic                  branchReg,
  output logic                  halt,
  output cpuPkg::aluOp_t        aluOp,
  output logic                  zEn,
  output logic                  nvEn
);

  import cpuPkg::*;

  ////////////////////
  // Decode
  ////////////////////
  always_comb begin
    regWrite  = 1'b0; // Everything idle by default
    memWrite  = 1'b0;
    memRead   = 1'b0;
    aluSrcImm = 1'b0;
    srcFromRd = 1'b0;
    memToReg  = 1'b0;
    pcToReg   = 1'b0;
    branch    = 1'b0;
    branchReg = 1'b0;
    halt      = 1'b0;
    aluOp     = aluAdd;
    zEn       = 1'b0;
    nvEn      = 1'b0;
    if (run) begin
      unique case (opcode)
        opAdd: begin regWrite = 1'b1; zEn = 1'b1; nvEn = 1'b1; end
        opSub: begin regWrite = 1'b1; aluOp = aluSub; zEn = 1'b1; nvEn = 1'b1; end
        opXor: begin regWrite = 1'b1; aluOp = aluXor; zEn = 1'b1; end
        opSll: begin regWrite = 1'b1; aluOp = aluSll; aluSrcImm = 1'b1; zEn = 1'b1; end
        opSra: begin regWrite = 1'b1; aluOp = aluSra; aluSrcImm = 1'b1; zEn = 1'b1; end
        opRor: begin regWrite = 1'b1; aluOp = aluRor; aluSrcImm = 1'b1; zEn = 1'b1; end
        opLw: begin
          regWrite  = 1'b1;
          memRead   = 1'b1;
          memToReg  = 1'b1;
          aluSrcImm = 1'b1;
          aluOp     = aluAddr; // Base plus offset
        end
        opSw:  begin memWrite = 1'b1; aluSrcImm = 1'b1; aluOp = aluAddr; end
        opLlb: begin regWrite = 1'b1; srcFromRd = 1'b1; aluSrcImm = 1'b1; aluOp = aluLlb; end
        opLhb: begin regWrite = 1'b1; srcFromRd = 1'b1; aluSrcImm = 1'b1; aluOp = aluLhb; end
        opB:   branch    = 1'b1;
        opBr:  branchReg = 1'b1;
        opPcs: begin regWrite = 1'b1; pcToReg = 1'b1; end
        opHlt: halt = 1'b1;
        default: ; // RED and PADDSB fall through as no-ops
      endcase
    end
  end

  // No opcode both stores and writes back
  storeNoWriteBack: assert final (!(memWrite && regWrite))
    else $error("controlUnit memWrite and regWrite both set for opcode %h", opcode);

endmodule

`default_nettype wire

//--- logic/cpu.sv
`default_nettype none

module cpu #(
  parameter int imemAddrWidth = 8,
  parameter int dmemAddrWidth = 8
) (
  input  wire                           clk,
  input  wire                           arstN,
  input  wire                           run,      // Low while a program loads
  input  wire                           loadEn,
  input  wire  [imemAddrWidth-1:0]      loadAddr, // Instruction word index
  input  wire  [cpuPkg::wordWidth-1:0]  loadData,
  output logic [cpuPkg::wordWidth-1:0]  pc,
  output logic                          hlt
);

  import cpuPkg::*;

  instrWord_t instr; // Fetched word, decoded several ways

  logic [imemAddrWidth-1:0] imemAddr;
  logic                     imemWrite;

  // Decode strobes
  logic   regWrite, memWrite, memRead, aluSrcImm, srcFromRd;
  logic   memToReg, pcToReg, branch, branchReg, zEn, nvEn;
  aluOp_t aluOp;

  logic [3:0]           readAddrA;
  logic [3:0]           readAddrB;
  logic [wordWidth-1:0] readDataA;
  logic [wordWidth-1:0] readDataB;
  logic [wordWidth-1:0] immValue;
  logic [wordWidth-1:0] opB;
  logic [wordWidth-1:0] aluResult;
  logic [wordWidth-1:0] memData;
  logic [wordWidth-1:0] writeBack;
  logic [wordWidth-1:0] pcPlus2;
  logic                 flagZ, flagN, flagV;

  ////////////////////
  // Fetch
  ////////////////////
  assign imemWrite = loadEn && !run;                         // Loader ignored while running
  assign imemAddr  = run ? pc[imemAddrWidth:1] : loadAddr;   // Byte pc to word index

  wordMemory #(.addrWidth(imemAddrWidth)) instrMem (
    .clk(clk), .arstN(arstN),
    .writeEn(imemWrite), .addr(imemAddr), .writeData(loadData),
    .readData(instr)
  );

  controlUnit ctrl (
    .opcode(instr.regForm.opcode), .run(run),
    .regWrite(regWrite), .memWrite(memWrite), .memRead(memRead),
    .aluSrcImm(aluSrcImm), .srcFromRd(srcFromRd), .memToReg(memToReg),
    .pcToReg(pcToReg), .branch(branch), .branchReg(branchReg),
    .halt(hlt), .aluOp(aluOp), .zEn(zEn), .nvEn(nvEn)
  );

  ////////////////////
  // Operands
  ////////////////////
  assign readAddrA = srcFromRd ? instr.byteForm.rd : instr.regForm.rs; // rd for byte loads
  assign readAddrB = memWrite ? instr.memForm.rt : instr.regForm.rt;   // Store data source

  registerFile regFile (
    .clk(clk), .arstN(arstN),
    .readAddrA(readAddrA), .readAddrB(readAddrB),
    .writeAddr(instr.regForm.rd), .writeEn(regWrite), .writeData(writeBack),
    .readDataA(readDataA), .readDataB(readDataB)
  );

  always_comb begin
    if (memRead || memWrite) begin
      immValue = {{(wordWidth-5){instr.memForm.offset[3]}}, instr.memForm.offset, 1'b0};
    end else if (srcFromRd) begin
      immValue = {{(wordWidth-8){1'b0}}, instr.byteForm.imm8};
    end else begin
      immValue = {{(wordWidth-4){1'b0}}, instr.regForm.rt}; // Shift amount
    end
  end

  assign opB = aluSrcImm ? immValue : readDataB;

  executeUnit exec (
    .clk(clk), .arstN(arstN),
    .opA(readDataA), .opB(opB), .aluOp(aluOp), .zEn(zEn), .nvEn(nvEn),
    .result(aluResult), .flagZ(flagZ), .flagN(flagN), .flagV(flagV)
  );

  ////////////////////
  // Memory and write-back
  ////////////////////
  wordMemory #(.addrWidth(dmemAddrWidth)) dataMem (
    .clk(clk), .arstN(arstN),
    .writeEn(memWrite), .addr(aluResult[dmemAddrWidth:1]), .writeData(readDataB),
    .readData(memData)
  );

  assign writeBack = memToReg ? memData : (pcToReg ? pcPlus2 : aluResult);

  ////////////////////
  // Next pc
  ////////////////////
  programCounter pcUnit (
    .clk(clk), .arstN(arstN),
    .hold(!run || hlt),                       // Frozen while loading or halted
    .branch(branch), .branchReg(branchReg),
    .cond(instr.branchForm.cond), .imm9(instr.branchForm.imm9),
    .regTarget(readDataA),                    // rs for BR
    .flagZ(flagZ), .flagN(flagN), .flagV(flagV),
    .pc(pc), .pcPlus2(pcPlus2)
  );

endmodule

`default_nettype wire

//--- logic/cpuPkg.sv
`default_nettype none

package cpuPkg;

  localparam int wordWidth = 16; // Data path and byte address width

  ////////////////////
  // Opcode map
  ////////////////////
  typedef enum logic [3:0] {
    opAdd  = 4'h0, // Saturating add
    opSub  = 4'h1, // Saturating subtract
    opXor  = 4'h2,
    opRed  = 4'h3, // Reduction, runs as a no-op
    opSll  = 4'h4,
    opSra  = 4'h5,
    opRor  = 4'h6,
    opPadd = 4'h7, // Packed add, runs as a no-op
    opLw   = 4'h8,
    opSw   = 4'h9,
    opLlb  = 4'hA, // Load low byte
    opLhb  = 4'hB, // Load high byte
    opB    = 4'hC, // Conditional branch
    opBr   = 4'hD, // Branch to register
    opPcs  = 4'hE, // Save pc+2
    opHlt  = 4'hF
  } opcode_t;

  // Branch condition codes against Z, N and V
  typedef enum logic [2:0] {
    condNe, condEq, condGt, condLt, condGe, condLe, condOv, condUn
  } cond_t;

  typedef enum logic [3:0] {
    aluAdd, aluSub, aluXor, aluSll, aluSra, aluRor, aluLlb, aluLhb,
    aluAddr // Plain add for load and store addresses
  } aluOp_t;

  ////////////////////
  // Instruction views
  ////////////////////
  typedef union packed {
    struct packed {
      opcode_t    opcode;
      logic [3:0] rd;
      logic [3:0] rs;
      logic [3:0] rt; // Also the shift amount
    } regForm;
    struct packed {
      opcode_t    opcode;
      logic [3:0] rt;     // Load target or store source
      logic [3:0] rs;     // Base register
      logic [3:0] offset; // Signed word offset
    } memForm;
    struct packed {
      opcode_t    opcode;
      logic [3:0] rd;
      logic [7:0] imm8;
    } byteForm;
    struct packed {
      opcode_t    opcode;
      cond_t      cond;
      logic [8:0] imm9; // Signed word displacement
    } branchForm;
  } instrWord_t;

endpackage

`default_nettype wire

//--- logic/executeUnit.sv
`default_nettype none

module executeUnit (
  input  wire                           clk,
  input  wire                           arstN,
  input  wire  [cpuPkg::wordWidth-1:0]  opA,
  input  wire  [cpuPkg::wordWidth-1:0]  opB,
  input  var   cpuPkg::aluOp_t          aluOp,
  input  wire                           zEn,
  input  wire                           nvEn,
  output logic [cpuPkg::wordWidth-1:0]  result,
  output logic                          flagZ,
  output logic                          flagN,
  output logic                          flagV
);

  import cpuPkg::*;

  localparam logic [wordWidth-1:0] satMax = {1'b0, {(wordWidth-1){1'b1}}}; // 7FFF
  localparam logic [wordWidth-1:0] satMin = {1'b1, {(wordWidth-1){1'b0}}}; // 8000

  logic [wordWidth-1:0]   sum;
  logic [wordWidth-1:0]   diff;
  logic                   addOvf;
  logic                   subOvf;
  logic                   overflow; // V for the current op
  logic [3:0]             shamt;
  logic [2*wordWidth-1:0] rotWide;  // Doubled word for rotate

  ////////////////////
  // Arithmetic
  ////////////////////
  assign sum    = opA + opB;
  assign diff   = opA - opB;
  assign addOvf = (opA[wordWidth-1] == opB[wordWidth-1]) && (sum[wordWidth-1] != opA[wordWidth-1]);
  assign subOvf = (opA[wordWidth-1] != opB[wordWidth-1]) && (diff[wordWidth-1] != opA[wordWidth-1]);
  assign overflow = (aluOp == aluSub) ? subOvf : addOvf;

  assign shamt   = opB[3:0];            // Low four bits only
  assign rotWide = {opA, opA} >> shamt;

  always_comb begin
    unique case (aluOp)
      aluAdd: begin
        if (addOvf) result = opA[wordWidth-1] ? satMin : satMax; // Clamp to signed range
        else        result = sum;
      end
      aluSub: begin
        if (subOvf) result = opA[wordWidth-1] ? satMin : satMax;
        else        result = diff;
      end
      aluXor:  result = opA ^ opB;
      aluSll:  result = opA << shamt;
      aluSra:  result = $unsigned($signed(opA) >>> shamt); // Sign fills from the left
      aluRor:  result = rotWide[wordWidth-1:0];
      aluLlb:  result = {opA[wordWidth-1:8], opB[7:0]}; // Keep high byte of rd
      aluLhb:  result = {opB[7:0], opA[7:0]};           // Keep low byte of rd
      default: result = sum; // Address add without clamping
    endcase
  end

  ////////////////////
  // Flag register
  ////////////////////
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      flagZ <= 1'b0;
      flagN <= 1'b0;
      flagV <= 1'b0;
    end else begin
      if (zEn)  flagZ <= (result == '0);
      if (nvEn) begin
        flagN <= result[wordWidth-1]; // N from the result sign
        flagV <= overflow;            // V from the overflow detect
      end
    end
  end

  // A clamped add keeps the sign of its operands in the registered N
  satAddKeepsSign: assert property (
    @(posedge clk) disable iff (!arstN)
    (nvEn && (aluOp == aluAdd) && addOvf) |=> (flagV && (flagN == $past(opA[wordWidth-1])))
  ) else $error("executeUnit saturated add flipped the operand sign");

endmodule

`default_nettype wire

//--- logic/programCounter.sv
`default_nettype none

module programCounter (
  input  wire                           clk,
  input  wire                           arstN,
  input  wire                           hold,      // Not running or halted
  input  wire                           branch,
  input  wire                           branchReg,
  input  var   cpuPkg::cond_t           cond,
  input  wire  [8:0]                    imm9,
  input  wire  [cpuPkg::wordWidth-1:0]  regTarget, // rs value for BR
  input  wire                           flagZ,
  input  wire                           flagN,
  input  wire                           flagV,
  output logic [cpuPkg::wordWidth-1:0]  pc,
  output logic [cpuPkg::wordWidth-1:0]  pcPlus2
);

  import cpuPkg::*;

  logic                 taken;
  logic [wordWidth-1:0] branchOffset; // Byte displacement
  logic [wordWidth-1:0] nextPc;

  ////////////////////
  // Condition check
  ////////////////////
  always_comb begin
    unique case (cond)
      condNe:  taken = !flagZ;
      condEq:  taken = flagZ;
      condGt:  taken = !flagZ && !flagN;
      condLt:  taken = flagN;
      condGe:  taken = flagZ || !flagN;
      condLe:  taken = flagZ || flagN;
      condOv:  taken = flagV;
      default: taken = 1'b1; // Unconditional
    endcase
  end

  assign pcPlus2      = pc + 16'd2;
  assign branchOffset = {{(wordWidth-10){imm9[8]}}, imm9, 1'b0}; // Sign extend then x2

  always_comb begin
    if (branchReg)            nextPc = {regTarget[wordWidth-1:1], 1'b0}; // Word aligned
    else if (branch && taken) nextPc = pcPlus2 + branchOffset;
    else                      nextPc = pcPlus2;
  end

  ////////////////////
  // PC register
  ////////////////////
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN)     pc <= '0;
    else if (!hold) pc <= nextPc;
  end

  pcAligned: assert property (
    @(posedge clk) disable iff (!arstN) !pc[0]
  ) else $error("programCounter pc %h is not word aligned", pc);

endmodule

`default_nettype wire

//--- logic/registerFile.sv
`default_nettype none

module registerFile (
  input  wire                           clk,
  input  wire                           arstN,
  input  wire  [3:0]                    readAddrA,
  input  wire  [3:0]                    readAddrB,
  input  wire  [3:0]                    writeAddr,
  input  wire                           writeEn,
  input  wire  [cpuPkg::wordWidth-1:0]  writeData,
  output logic [cpuPkg::wordWidth-1:0]  readDataA,
  output logic [cpuPkg::wordWidth-1:0]  readDataB
);

  import cpuPkg::*;

  logic [wordWidth-1:0] regs [16]; // r0 slot is never written

  ////////////////////
  // Write port
  ////////////////////
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      regs <= '{default: '0};
    end else if (writeEn && (writeAddr != 4'd0)) begin // Drop writes to r0
      regs[writeAddr] <= writeData;
    end
  end

  ////////////////////
  // Read ports
  ////////////////////
  // No bypass so a same-cycle read sees the old value
  always_comb begin
    readDataA = (readAddrA == 4'd0) ? '0 : regs[readAddrA];
    readDataB = (readAddrB == 4'd0) ? '0 : regs[readAddrB];
  end

endmodule

`default_nettype wire

//--- logic/wordMemory.sv
`default_nettype none

module wordMemory #(
  parameter int addrWidth = 8
) (
  input  wire                           clk,
  input  wire                           arstN,
  input  wire                           writeEn,
  input  wire  [addrWidth-1:0]          addr,     // Word address
  input  wire  [cpuPkg::wordWidth-1:0]  writeData,
  output logic [cpuPkg::wordWidth-1:0]  readData
);

  import cpuPkg::*;

  localparam int depth = 2 ** addrWidth;

  logic [wordWidth-1:0] mem [depth]; // Storage array

  ////////////////////
  // Write port
  ////////////////////
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      mem <= '{default: '0}; // Whole array comes up zero
    end else if (writeEn) begin
      mem[addr] <= writeData; // One word per edge
    end
  end

  // Asynchronous read
  assign readData = mem[addr];

  // A write to an unknown address would corrupt an arbitrary word
  addrKnownOnWrite: assert property (
    @(posedge clk) disable iff (!arstN)
    writeEn |-> !$isunknown(addr)
  ) else $error("wordMemory write with unknown address %h", addr);

endmodule

`default_nettype wire

//--- sim/cpuTbModel.svh
`ifndef CPU_TB_MODEL_SVH
`define CPU_TB_MODEL_SVH

////////////////////
// Random source
////////////////////
logic [31:0] lfsrState = 32'd83686;

function automatic logic lfsrBit();
  logic fb;
  fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0]; // Taps 32,22,2,1
  lfsrState = {lfsrState[30:0], fb};
  return fb;
endfunction

function automatic logic [15:0] randBits(int n);
  logic [15:0] v;
  v = '0;
  for (int i = 0; i < n; i++) v = {v[14:0], lfsrBit()}; // One step per bit
  return v;
endfunction

////////////////////
// Architectural state of the model
////////////////////
logic [15:0] mRegs [16];
logic [15:0] mDmem [256];
logic [15:0] mImem [256];
logic [15:0] mPc;
logic        mZ, mN, mV;

task automatic modelReset();
  for (int i = 0; i < 256; i++) begin
    mDmem[i] = '0;
    mImem[i] = '0;
  end
  for (int i = 0; i < 16; i++) mRegs[i] = '0;
  mPc = '0;
  mZ  = 1'b0;
  mN  = 1'b0;
  mV  = 1'b0;
endtask

// {overflow, clamped result} of a signed add or subtract
function automatic logic [16:0] satArith(logic [15:0] a, logic [15:0] b, logic isSub);
  int full;
  full = isSub ? $signed(a) - $signed(b) : $signed(a) + $signed(b);
  if (full > 32767) return {1'b1, 16'h7FFF};
  if (full < -32768) return {1'b1, 16'h8000};
  return {1'b0, full[15:0]};
endfunction

function automatic logic condHolds(logic [2:0] c);
  case (c)
    3'd0: return !mZ;
    3'd1: return mZ;
    3'd2: return !mZ && !mN;
    3'd3: return mN;
    3'd4: return mZ || !mN;
    3'd5: return mZ || mN;
    3'd6: return mV;
    default: return 1'b1;
  endcase
endfunction

task automatic writeReg(logic [3:0] r, logic [15:0] v);
  if (r != 4'd0) mRegs[r] = v; // r0 stays zero
endtask
`endif

//--- sim/cpuTb.sv
`default_nettype none

module cpuTb;
  timeunit 1ns;
  timeprecision 100ps;

  import cpuPkg::*;

  `include "cpuTbModel.svh"

  localparam int numTests  = 40;
  localparam int maxProg   = 16;
  localparam int stepLimit = 40; // Steps per test before the run is dropped
  localparam int period    = 10;

  logic        clk, arstN, run, loadEn;
  logic [7:0]  loadAddr;
  logic [15:0] loadData;
  logic [15:0] pc;
  logic        hlt;

  logic [15:0] prog [$];
  logic        modelRun;
  logic        expHlt;
  string       testName;
  int          pcErrors, hltErrors;

  cpu dut (
    .clk(clk), .arstN(arstN), .run(run), .loadEn(loadEn),
    .loadAddr(loadAddr), .loadData(loadData), .pc(pc), .hlt(hlt)
  );

  initial begin
    clk = 1'b0;
    forever #(period / 2) clk = ~clk;
  end

  ////////////////////
  // Checks against the model
  ////////////////////
  pcMatches: assert property (@(posedge clk) disable iff (!arstN) pc == mPc)
    else begin
      pcErrors++;
      $display("ERR %s pc expected %h actual %h", testName, $sampled(mPc), $sampled(pc));
    end

  hltMatches: assert property (@(posedge clk) disable iff (!arstN) hlt == expHlt)
    else begin
      hltErrors++;
      $display("ERR %s hlt expected %b actual %b", testName, $sampled(expHlt), $sampled(hlt));
    end

  // Expected hlt follows the word at the model pc
  function automatic logic haltExpected();
    instrWord_t iw;
    iw = mImem[mPc[8:1]];
    return modelRun && (iw.regForm.opcode == opHlt);
  endfunction

  ////////////////////
  // Instruction builders
  ////////////////////
  function automatic logic [15:0] regInstr(opcode_t op, logic [3:0] rd, logic [3:0] rs,
                                           logic [3:0] rt);
    instrWord_t iw;
    iw.regForm = '{opcode: op, rd: rd, rs: rs, rt: rt};
    return iw;
  endfunction

  function automatic logic [15:0] byteInstr(opcode_t op, logic [3:0] rd, logic [7:0] imm);
    instrWord_t iw;
    iw.byteForm = '{opcode: op, rd: rd, imm8: imm};
    return iw;
  endfunction

  function automatic logic [15:0] memInstr(opcode_t op, logic [3:0] rt, logic [3:0] rs,
                                           logic [3:0] off);
    instrWord_t iw;
    iw.memForm = '{opcode: op, rt: rt, rs: rs, offset: off};
    return iw;
  endfunction

  function automatic logic [15:0] branchInstr(cond_t c, logic [8:0] imm);
    instrWord_t iw;
    iw.branchForm = '{opcode: opB, cond: c, imm9: imm};
    return iw;
  endfunction

  // High byte pulled toward the saturation corners now and then
  function automatic logic [7:0] edgyHigh();
    logic [1:0] pick;
    pick = randBits(2);
    if (pick == 2'd0) return 8'h7F;
    if (pick == 2'd1) return 8'h80;
    return randBits(8);
  endfunction

  task automatic loadOperand(logic [3:0] r);
    prog.push_back(byteInstr(opLlb, r, randBits(8)));
    prog.push_back(byteInstr(opLhb, r, edgyHigh()));
  endtask

  ////////////////////
  // Model step, one retired instruction
  ////////////////////
  task automatic modelStep();
    instrWord_t  iw;
    logic [15:0] a, b, res, addr, nextPc;
    logic [16:0] sat;
    iw     = mImem[mPc[8:1]];
    a      = mRegs[iw.regForm.rs];
    b      = mRegs[iw.regForm.rt];
    nextPc = mPc + 16'd2;
    addr   = a + {{11{iw.memForm.offset[3]}}, iw.memForm.offset, 1'b0};
    case (iw.regForm.opcode)
      opHlt: return; // Frozen
      opAdd, opSub: begin
        sat = satArith(a, b, iw.regForm.opcode == opSub);
        writeReg(iw.regForm.rd, sat[15:0]);
        mZ = (sat[15:0] == 16'd0);
        mN = sat[15];
        mV = sat[16];
      end
      opXor, opSll, opSra, opRor: begin
        case (iw.regForm.opcode)
          opXor: res = a ^ b;
          opSll: res = a << iw.regForm.rt;
          opSra: res = $signed(a) >>> iw.regForm.rt;
          default: res = (a >> iw.regForm.rt) | (a << (5'd16 - iw.regForm.rt)); // Wrap
        endcase
        writeReg(iw.regForm.rd, res);
        mZ = (res == 16'd0); // N and V untouched
      end
      opLw:  writeReg(iw.memForm.rt, mDmem[addr[8:1]]);
      opSw:  mDmem[addr[8:1]] = mRegs[iw.memForm.rt];
      opLlb: writeReg(iw.byteForm.rd, {mRegs[iw.byteForm.rd][15:8], iw.byteForm.imm8});
      opLhb: writeReg(iw.byteForm.rd, {iw.byteForm.imm8, mRegs[iw.byteForm.rd][7:0]});
      opB: if (condHolds(iw.branchForm.cond))
             nextPc = nextPc + {{6{iw.branchForm.imm9[8]}}, iw.branchForm.imm9, 1'b0};
      opBr:  nextPc = a & 16'hFFFE;
      opPcs: writeReg(iw.regForm.rd, mPc + 16'd2);
      default: ; // Opcodes 3 and 7 do nothing
    endcase
    mPc = nextPc;
  endtask

  ////////////////////
  // Program generator
  ////////////////////
  task automatic buildProgram(int idx);
    opcode_t aluOps [6];
    opcode_t op;
    logic [3:0] off;
    aluOps = '{opAdd, opSub, opXor, opSll, opSra, opRor};
    prog.delete();
    if (idx < 1 || idx >= 38) begin
      testName = "straight";
      for (int i = 0; i < 6; i++) prog.push_back(byteInstr(opLlb, randBits(4), randBits(8)));
      prog.push_back(regInstr(opHlt, 0, 0, 0));
    end else if (idx < 13) begin
      testName = "alu";
      loadOperand(4'd1);
      loadOperand(4'd2);
      op = aluOps[randBits(3) % 6];
      if (op inside {opAdd, opSub, opXor}) prog.push_back(regInstr(op, 3, 1, 2));
      else prog.push_back(regInstr(op, 3, 1, randBits(4))); // Immediate shift count
      prog.push_back(regInstr(opBr, 0, 3, 0));
    end else if (idx < 29) begin
      testName = "branch";
      loadOperand(4'd1);
      loadOperand(4'd2);
      if (lfsrBit()) prog.push_back(regInstr(opSub, 3, 1, 2));
      else prog.push_back(regInstr(opAdd, 3, 1, 2));
      if (lfsrBit()) prog.push_back(regInstr(opXor, 4, 1, 2)); // Z only
      else prog.push_back(byteInstr(opLlb, 5, 8'h11));
      prog.push_back(branchInstr(cond_t'(idx % 8), 9'd1));
      prog.push_back(regInstr(opHlt, 0, 0, 0)); // Stops here when not taken
      prog.push_back(regInstr(opHlt, 0, 0, 0));
    end else if (idx < 34) begin
      testName = "memory";
      off = randBits(4);
      loadOperand(4'd1);
      prog.push_back(byteInstr(opLlb, 2, randBits(8)));
      prog.push_back(byteInstr(opLhb, 2, 8'h00));
      prog.push_back(memInstr(opSw, 1, 2, off));
      prog.push_back(byteInstr(opLlb, 1, 8'h00)); // Clobber the source
      prog.push_back(byteInstr(opLhb, 1, 8'h00));
      prog.push_back(memInstr(opLw, 4, 2, off));
      prog.push_back(regInstr(opBr, 0, 4, 0));
    end else if (idx < 36) begin
      testName = "pcs";
      prog.push_back(byteInstr(opLlb, 6, randBits(8)));
      prog.push_back(regInstr(opPcs, 5, 0, 0));
      prog.push_back(byteInstr(opLlb, 7, randBits(8)));
      prog.push_back(regInstr(opBr, 0, 5, 0)); // Back to the word after PCS
    end else begin
      testName = "r0";
      loadOperand(4'd1);
      prog.push_back(byteInstr(opLlb, 0, randBits(8)));
      prog.push_back(regInstr(opAdd, 0, 1, 1));
      prog.push_back(regInstr(opBr, 0, 0, 0));
    end
  endtask

  ////////////////////
  // Test sequence
  ////////////////////
  task automatic resetCore();
    @(negedge clk);
    arstN = 1'b0;
    modelReset();
    modelRun = 1'b0;
    expHlt   = 1'b0;
    repeat (3) @(negedge clk);
    arstN = 1'b1;
  endtask

  task automatic loadProgram();
    foreach (prog[i]) begin
      loadEn   = 1'b1;
      loadAddr = i[7:0];
      loadData = prog[i];
      @(posedge clk);
      mImem[i] = prog[i]; // Mirror the written word
      @(negedge clk);
    end
    loadEn = 1'b0;
  endtask

  task automatic runProgram();
    int steps;
    int haltedFor;
    steps     = 0;
    haltedFor = 0;
    run       = 1'b1;
    modelRun  = 1'b1;
    expHlt    = haltExpected();
    while (steps < stepLimit && haltedFor < 3) begin
      @(posedge clk);
      @(negedge clk);
      modelStep();
      expHlt = haltExpected();
      if (expHlt) haltedFor++; // A few frozen cycles are checked too
      steps++;
    end
    run      = 1'b0;
    modelRun = 1'b0;
    expHlt   = 1'b0;
  endtask

  initial begin
    #(numTests * (maxProg + stepLimit) * period * 2);
    $display("Watchdog expired before the tests finished, the run hung");
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    arstN     = 1'b0;
    run       = 1'b0;
    loadEn    = 1'b0;
    loadAddr  = '0;
    loadData  = '0;
    modelRun  = 1'b0;
    expHlt    = 1'b0;
    pcErrors  = 0;
    hltErrors = 0;
    testName  = "reset";
    modelReset();
    for (int t = 0; t < numTests; t++) begin
      resetCore();
      buildProgram(t);
      loadProgram();
      runProgram();
    end
    @(negedge clk);
    $display("Errors: pc %0d, hlt %0d, total %0d", pcErrors, hltErrors, pcErrors + hltErrors);
    if (pcErrors + hltErrors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
+incdir+sim
logic/cpuPkg.sv
logic/wordMemory.sv
logic/registerFile.sv
logic/controlUnit.sv
logic/executeUnit.sv
logic/programCounter.sv
logic/cpu.sv
sim/cpuTb.sv
